// File: csr_pkg.sv
package csr_pkg;

  // Machine-mode CSR addresses.
  localparam logic [11:0] CSR_MSTATUS   = 12'h300;
  localparam logic [11:0] CSR_MTVEC     = 12'h305;
  localparam logic [11:0] CSR_MEPC      = 12'h341;
  localparam logic [11:0] CSR_MCAUSE    = 12'h342;
  localparam logic [11:0] CSR_MVENDORID = 12'hF11;
  localparam logic [11:0] CSR_MARCHID   = 12'hF12;

  // Read-only identity values.
  localparam logic [31:0] MVENDORID_VAL = 32'h7973_7978;
  localparam logic [31:0] MARCHID_VAL   = 32'h015F_DE77;

  // Interrupt enable bits in mstatus.
  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_MPIE = 7;

  // Environment call from M-mode.
  localparam logic [31:0] CAUSE_ECALL_M = 32'd11;

  // Request opcode from the execute stage.
  typedef enum logic [2:0] {
    CSR_RW    = 3'd0, // csrrw.
    CSR_RS    = 3'd1, // csrrs.
    CSR_RC    = 3'd2, // csrrc.
    CSR_ECALL = 3'd3, // Trap entry.
    CSR_MRET  = 3'd4  // Trap return.
  } csr_op_e;

  // Handshake states.
  typedef enum logic [1:0] {
    IDLE = 2'd0, // Waiting for req.
    EXEC = 2'd1, // Commit cycle.
    DONE = 2'd2  // Results held, ack follows req.
  } req_state_e;

endpackage

// File: csr_regfile.sv
`timescale 1ns/100ps

module csr_regfile import csr_pkg::*; #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            commit,
  input  logic            wen,
  input  logic [11:0]     waddr,
  input  logic [XLEN-1:0] wdata,
  input  logic            wen_add1,
  input  logic [11:0]     waddr_add1,
  input  logic [XLEN-1:0] wdata_add1,
  input  logic            ecall,
  input  logic            mret,
  output logic [XLEN-1:0] rdata,
  output logic [XLEN-1:0] mtvec,
  output logic [XLEN-1:0] mepc
);

  logic [XLEN-1:0] mstatus_q;
  logic [XLEN-1:0] mepc_q;
  logic [XLEN-1:0] mtvec_q;
  logic [XLEN-1:0] mcause_q;

  // Per-register write selects for both ports.
  logic sel0_mstatus, sel0_mepc, sel0_mtvec, sel0_mcause;
  logic sel1_mstatus, sel1_mepc, sel1_mtvec, sel1_mcause;

  assign sel0_mstatus = wen && (waddr == CSR_MSTATUS);
  assign sel0_mepc    = wen && (waddr == CSR_MEPC);
  assign sel0_mtvec   = wen && (waddr == CSR_MTVEC);
  assign sel0_mcause  = wen && (waddr == CSR_MCAUSE);

  assign sel1_mstatus = wen_add1 && (waddr_add1 == CSR_MSTATUS);
  assign sel1_mepc    = wen_add1 && (waddr_add1 == CSR_MEPC);
  assign sel1_mtvec   = wen_add1 && (waddr_add1 == CSR_MTVEC);
  assign sel1_mcause  = wen_add1 && (waddr_add1 == CSR_MCAUSE);

  // Old value at the port 0 address.
  always_comb begin
    case (waddr)
      CSR_MSTATUS:   rdata = mstatus_q;
      CSR_MEPC:      rdata = mepc_q;
      CSR_MTVEC:     rdata = mtvec_q;
      CSR_MCAUSE:    rdata = mcause_q;
      CSR_MVENDORID: rdata = XLEN'(MVENDORID_VAL);
      CSR_MARCHID:   rdata = XLEN'(MARCHID_VAL);
      default:       rdata = '0; // Unimplemented address.
    endcase
  end

  assign mtvec = mtvec_q;
  assign mepc  = mepc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mepc_q    <= '0;
      mtvec_q   <= '0;
      mcause_q  <= '0;
    end else if (commit) begin
      // Port 1 has priority when both ports hit the same CSR.
      if (sel1_mstatus) mstatus_q <= wdata_add1;
      else if (sel0_mstatus) mstatus_q <= wdata;
      if (sel1_mepc) mepc_q <= wdata_add1;
      else if (sel0_mepc) mepc_q <= wdata;
      if (sel1_mtvec) mtvec_q <= wdata_add1;
      else if (sel0_mtvec) mtvec_q <= wdata;
      if (sel1_mcause) mcause_q <= wdata_add1;
      else if (sel0_mcause) mcause_q <= wdata;

      // Interrupt enable stacking overrides port writes to these bits.
      if (ecall) begin
        mstatus_q[MSTATUS_MPIE] <= mstatus_q[MSTATUS_MIE];
        mstatus_q[MSTATUS_MIE]  <= 1'b0;
      end else if (mret) begin
        mstatus_q[MSTATUS_MIE]  <= mstatus_q[MSTATUS_MPIE];
        mstatus_q[MSTATUS_MPIE] <= 1'b1;
      end
    end
  end

endmodule

// File: csr_alu.sv
`timescale 1ns/100ps

module csr_alu import csr_pkg::*; #(
  parameter int XLEN = 32
) (
  input  csr_op_e         op,
  input  logic [XLEN-1:0] src,
  input  logic [XLEN-1:0] old,
  output logic [XLEN-1:0] new_val,
  output logic            wen
);

  logic src_nz;

  // Set and clear only write back with a nonzero mask.
  assign src_nz = |src;

  always_comb begin
    case (op)
      CSR_RW: begin
        new_val = src;
        wen     = 1'b1;
      end
      CSR_RS: begin
        new_val = old | src; // Set bits.
        wen     = src_nz;
      end
      CSR_RC: begin
        new_val = old & ~src; // Clear bits.
        wen     = src_nz;
      end
      default: begin
        // Trap operations leave port 0 to trap_ctrl.
        new_val = old;
        wen     = 1'b0;
      end
    endcase
  end

endmodule

// File: trap_ctrl.sv
`timescale 1ns/100ps

module trap_ctrl import csr_pkg::*; #(
  parameter int XLEN = 32
) (
  input  csr_op_e         op,
  input  logic [11:0]     addr,
  input  logic [XLEN-1:0] pc,
  input  logic [XLEN-1:0] alu_val,
  input  logic            alu_wen,
  input  logic [XLEN-1:0] mtvec,
  input  logic [XLEN-1:0] mepc,
  output logic            wen,
  output logic [11:0]     waddr,
  output logic [XLEN-1:0] wdata,
  output logic            wen_add1,
  output logic [11:0]     waddr_add1,
  output logic [XLEN-1:0] wdata_add1,
  output logic            ecall,
  output logic            mret,
  output logic            redirect,
  output logic [XLEN-1:0] redirect_pc
);

  assign ecall = (op == CSR_ECALL);
  assign mret  = (op == CSR_MRET);

  // Port 1 is only ever used to record the trap cause.
  assign waddr_add1 = CSR_MCAUSE;
  assign wdata_add1 = XLEN'(CAUSE_ECALL_M);
  assign wen_add1   = ecall;

  always_comb begin
    // Plain CSR access by default. alu_wen is low for trap ops.
    wen         = alu_wen;
    waddr       = addr;
    wdata       = alu_val;
    redirect    = 1'b0;
    redirect_pc = '0;
    if (ecall) begin
      wen         = 1'b1;
      waddr       = CSR_MEPC; // Save the faulting pc.
      wdata       = pc;
      redirect    = 1'b1;
      redirect_pc = mtvec;
    end else if (mret) begin
      redirect    = 1'b1;
      redirect_pc = mepc; // Back to the saved pc.
    end
  end

endmodule

// File: csr_req_ctrl.sv
`timescale 1ns/100ps

module csr_req_ctrl import csr_pkg::*; #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            req,
  input  csr_op_e         op_in,
  input  logic [11:0]     addr_in,
  input  logic [XLEN-1:0] src_in,
  input  logic [XLEN-1:0] pc_in,
  input  logic [XLEN-1:0] old_val,
  input  logic            redirect_in,
  input  logic [XLEN-1:0] redirect_pc_in,
  output logic            ack,
  output csr_op_e         op,
  output logic [11:0]     addr,
  output logic [XLEN-1:0] src,
  output logic [XLEN-1:0] pc,
  output logic            commit,
  output logic [XLEN-1:0] rdata,
  output logic            redirect,
  output logic [XLEN-1:0] redirect_pc
);

  req_state_e state;

  // One commit cycle per accepted request.
  assign commit = (state == EXEC);

  // Request fields, held stable for the whole transaction.
  always_ff @(posedge clk) begin
    if ((state == IDLE) && req) begin
      op   <= op_in;
      addr <= addr_in;
      src  <= src_in;
      pc   <= pc_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= IDLE;
      ack         <= 1'b0;
      rdata       <= '0;
      redirect    <= 1'b0;
      redirect_pc <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req) state <= EXEC;
        end
        EXEC: begin
          // Latch results on the same edge the CSRs update.
          rdata       <= old_val;
          redirect    <= redirect_in;
          redirect_pc <= redirect_pc_in;
          state       <= DONE;
        end
        DONE: begin
          if (req) begin
            ack <= 1'b1; // Hold while the requester keeps req high.
          end else begin
            ack   <= 1'b0;
            state <= IDLE;
          end
        end
        default: begin
          ack   <= 1'b0;
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

// File: csr_unit.sv
`timescale 1ns/100ps

module csr_unit import csr_pkg::*; #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            req,
  input  csr_op_e         op,
  input  logic [11:0]     addr,
  input  logic [XLEN-1:0] src,
  input  logic [XLEN-1:0] pc,
  output logic            ack,
  output logic [XLEN-1:0] rdata,
  output logic            redirect,
  output logic [XLEN-1:0] redirect_pc
);

  csr_op_e         op_q;
  logic [11:0]     addr_q;
  logic [XLEN-1:0] src_q, pc_q;
  logic            commit;
  logic [XLEN-1:0] old_val, mtvec, mepc;
  logic [XLEN-1:0] alu_val;
  logic            alu_wen;
  logic            wen, wen_add1, ecall, mret;
  logic [11:0]     waddr, waddr_add1;
  logic [XLEN-1:0] wdata, wdata_add1;
  logic            trap_redirect;
  logic [XLEN-1:0] trap_redirect_pc;

  csr_req_ctrl #(.XLEN(XLEN)) csr_req_ctrl_inst (
    .clk(clk), .rst(rst), .req(req),
    .op_in(op), .addr_in(addr), .src_in(src), .pc_in(pc),
    .old_val(old_val), .redirect_in(trap_redirect), .redirect_pc_in(trap_redirect_pc),
    .ack(ack), .op(op_q), .addr(addr_q), .src(src_q), .pc(pc_q), .commit(commit),
    .rdata(rdata), .redirect(redirect), .redirect_pc(redirect_pc)
  );

  csr_regfile #(.XLEN(XLEN)) csr_regfile_inst (
    .clk(clk), .rst(rst), .commit(commit),
    .wen(wen), .waddr(waddr), .wdata(wdata),
    .wen_add1(wen_add1), .waddr_add1(waddr_add1), .wdata_add1(wdata_add1),
    .ecall(ecall), .mret(mret),
    .rdata(old_val), .mtvec(mtvec), .mepc(mepc)
  );

  csr_alu #(.XLEN(XLEN)) csr_alu_inst (
    .op(op_q), .src(src_q), .old(old_val), .new_val(alu_val), .wen(alu_wen)
  );

  trap_ctrl #(.XLEN(XLEN)) trap_ctrl_inst (
    .op(op_q), .addr(addr_q), .pc(pc_q), .alu_val(alu_val), .alu_wen(alu_wen),
    .mtvec(mtvec), .mepc(mepc),
    .wen(wen), .waddr(waddr), .wdata(wdata),
    .wen_add1(wen_add1), .waddr_add1(waddr_add1), .wdata_add1(wdata_add1),
    .ecall(ecall), .mret(mret), .redirect(trap_redirect), .redirect_pc(trap_redirect_pc)
  );

endmodule

// File: tb_csr_unit.sv
`timescale 1ns/100ps

module tb_csr_unit import csr_pkg::*; ();

  localparam int XLEN      = 32;
  localparam int MAX_ROWS  = 64;
  localparam int ACK_LIMIT = 8; // Cycles to wait for an ack edge.

  logic            clk;
  logic            rst;
  logic            req;
  csr_op_e         op;
  logic [11:0]     addr;
  logic [XLEN-1:0] src;
  logic [XLEN-1:0] pc;
  logic            ack;
  logic [XLEN-1:0] rdata;
  logic            redirect;
  logic [XLEN-1:0] redirect_pc;

  // Stimulus and expected results, one entry per handshake.
  csr_op_e         t_op [0:MAX_ROWS-1];
  logic [11:0]     t_addr [0:MAX_ROWS-1];
  logic [XLEN-1:0] t_src [0:MAX_ROWS-1];
  logic [XLEN-1:0] t_pc [0:MAX_ROWS-1];
  logic [XLEN-1:0] t_rdata [0:MAX_ROWS-1];
  logic            t_chk_rdata [0:MAX_ROWS-1];
  logic            t_redirect [0:MAX_ROWS-1];
  logic [XLEN-1:0] t_rpc [0:MAX_ROWS-1];
  int              t_hold [0:MAX_ROWS-1];
  int              n_rows = 0;
  logic            table_built = 1'b0;

  // Expected CSR state while the table is built.
  logic [XLEN-1:0] m_mstatus = '0;
  logic [XLEN-1:0] m_mepc = '0;
  logic [XLEN-1:0] m_mtvec = '0;
  logic [XLEN-1:0] m_mcause = '0;

  integer seed = 19564;
  int     errors = 0;
  int     n_pass = 0;
  int     n_fail = 0;

  csr_unit #(.XLEN(XLEN)) csr_unit_inst (
    .clk(clk), .rst(rst), .req(req), .op(op), .addr(addr), .src(src), .pc(pc),
    .ack(ack), .rdata(rdata), .redirect(redirect), .redirect_pc(redirect_pc)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [XLEN-1:0] model_read(input logic [11:0] a);
    case (a)
      CSR_MSTATUS:   return m_mstatus;
      CSR_MEPC:      return m_mepc;
      CSR_MTVEC:     return m_mtvec;
      CSR_MCAUSE:    return m_mcause;
      CSR_MVENDORID: return MVENDORID_VAL;
      CSR_MARCHID:   return MARCHID_VAL;
      default:       return '0;
    endcase
  endfunction

  task automatic model_write(input logic [11:0] a, input logic [XLEN-1:0] d);
    case (a)
      CSR_MSTATUS: m_mstatus = d;
      CSR_MEPC:    m_mepc = d;
      CSR_MTVEC:   m_mtvec = d;
      CSR_MCAUSE:  m_mcause = d;
      default:     ; // Read-only and unknown addresses keep their value.
    endcase
  endtask

  task automatic add_row(input csr_op_e op_v, input logic [11:0] addr_v,
                         input logic [XLEN-1:0] src_v, input logic [XLEN-1:0] pc_v,
                         input int hold_v);
    logic [XLEN-1:0] old_v;
    begin
      old_v = model_read(addr_v);
      t_op[n_rows] = op_v;
      t_addr[n_rows] = addr_v;
      t_src[n_rows] = src_v;
      t_pc[n_rows] = pc_v;
      t_hold[n_rows] = hold_v;
      t_rdata[n_rows] = old_v;
      t_chk_rdata[n_rows] = 1'b1;
      t_redirect[n_rows] = 1'b0;
      t_rpc[n_rows] = '0;
      case (op_v)
        CSR_RW: model_write(addr_v, src_v);
        CSR_RS: if (src_v != 0) model_write(addr_v, old_v | src_v);
        CSR_RC: if (src_v != 0) model_write(addr_v, old_v & ~src_v);
        CSR_ECALL: begin
          t_chk_rdata[n_rows] = 1'b0;
          t_redirect[n_rows] = 1'b1;
          t_rpc[n_rows] = m_mtvec; // Jump to the trap vector.
          m_mepc = pc_v;
          m_mcause = CAUSE_ECALL_M;
          m_mstatus[MSTATUS_MPIE] = m_mstatus[MSTATUS_MIE];
          m_mstatus[MSTATUS_MIE] = 1'b0;
        end
        default: begin
          t_chk_rdata[n_rows] = 1'b0;
          t_redirect[n_rows] = 1'b1;
          t_rpc[n_rows] = m_mepc;
          m_mstatus[MSTATUS_MIE] = m_mstatus[MSTATUS_MPIE];
          m_mstatus[MSTATUS_MPIE] = 1'b1;
        end
      endcase
      n_rows = n_rows + 1;
    end
  endtask

  task automatic build_table;
    begin
      // Reset values, read with a zero mask.
      add_row(CSR_RS, CSR_MSTATUS, 0, 0, 0);
      add_row(CSR_RS, CSR_MEPC, 0, 0, 0);
      add_row(CSR_RS, CSR_MTVEC, 0, 0, 0);
      add_row(CSR_RS, CSR_MCAUSE, 0, 0, 0);
      add_row(CSR_RW, CSR_MTVEC, 32'h0000_1000, 0, 0);
      add_row(CSR_RS, CSR_MTVEC, $random(seed), 0, 2);
      add_row(CSR_RC, CSR_MTVEC, $random(seed), 0, 0);
      add_row(CSR_RS, CSR_MTVEC, 0, 0, 0);
      add_row(CSR_RC, CSR_MTVEC, 0, 0, 0);
      add_row(CSR_RW, CSR_MTVEC, 32'h8000_0100, 0, 0);
      add_row(CSR_RW, CSR_MEPC, $random(seed), 0, 0);
      add_row(CSR_RC, CSR_MEPC, 32'h0000_0003, 0, 0);
      add_row(CSR_RS, CSR_MEPC, 32'h0000_0101, 0, 0);
      add_row(CSR_RS, CSR_MEPC, 0, 0, 0);
      add_row(CSR_RW, CSR_MCAUSE, $random(seed), 0, 0);
      add_row(CSR_RS, CSR_MCAUSE, $random(seed), 0, 0);
      add_row(CSR_RC, CSR_MCAUSE, 32'hFFFF_FFFF, 0, 0);
      add_row(CSR_RS, CSR_MCAUSE, 0, 0, 0);
      // Leaves mstatus with only MIE set.
      add_row(CSR_RW, CSR_MSTATUS, 32'h0000_1880, 0, 0);
      add_row(CSR_RC, CSR_MSTATUS, 32'h0000_1880, 0, 3);
      add_row(CSR_RS, CSR_MSTATUS, 32'h0000_0008, 0, 0);
      add_row(CSR_RS, CSR_MSTATUS, 0, 0, 0);
      add_row(CSR_RS, CSR_MVENDORID, 0, 0, 0);
      add_row(CSR_RW, CSR_MVENDORID, $random(seed), 0, 0);
      add_row(CSR_RS, CSR_MVENDORID, 0, 0, 0);
      add_row(CSR_RC, CSR_MARCHID, 32'hFFFF_FFFF, 0, 0);
      add_row(CSR_RS, CSR_MARCHID, 0, 0, 0);
      add_row(CSR_RW, 12'h7C0, $random(seed), 0, 0); // Unimplemented CSR.
      add_row(CSR_RS, 12'h7C0, 0, 0, 0);
      add_row(CSR_ECALL, 12'h000, 0, 32'h0000_2468, 3);
      add_row(CSR_RS, CSR_MEPC, 0, 0, 0);
      add_row(CSR_RS, CSR_MCAUSE, 0, 0, 0);
      add_row(CSR_RS, CSR_MSTATUS, 0, 0, 0);
      add_row(CSR_MRET, 12'h000, 0, 0, 2);
      add_row(CSR_RS, CSR_MSTATUS, 0, 0, 0);
    end
  endtask

  task automatic check_outputs(input int r);
    if (t_chk_rdata[r] && rdata !== t_rdata[r]) begin
      $display("** Error: row %0d rdata expected %h, got %h", r, t_rdata[r], rdata);
      errors++;
    end
    if (redirect !== t_redirect[r]) begin
      $display("** Error: row %0d redirect expected %h, got %h", r, t_redirect[r], redirect);
      errors++;
    end
    if (t_redirect[r] && redirect_pc !== t_rpc[r]) begin
      $display("** Error: row %0d redirect_pc expected %h, got %h", r, t_rpc[r], redirect_pc);
      errors++;
    end
  endtask

  // One full four-phase handshake for table row r.
  task automatic run_row(input int r);
    int              lat;
    int              start_errors;
    logic [XLEN-1:0] rdata_s;
    logic            redir_s;
    logic [XLEN-1:0] rpc_s;
    begin
      start_errors = errors;
      @(posedge clk);
      req  <= 1'b1;
      op   <= t_op[r];
      addr <= t_addr[r];
      src  <= t_src[r];
      pc   <= t_pc[r];
      @(negedge clk);
      @(negedge clk); // Just after the edge that sees req.
      lat = 0;
      while (ack !== 1'b1 && lat < ACK_LIMIT) begin
        @(negedge clk);
        lat = lat + 1;
      end
      if (ack !== 1'b1) begin
        $display("Row %0d: the DUT gave no ack within %0d cycles", r, ACK_LIMIT);
        errors++;
      end else begin
        if (lat != 2) begin
          $display("Row %0d: ack rose %0d cycles after req was seen instead of 2", r, lat);
          errors++;
        end
        check_outputs(r);
        rdata_s = rdata;
        redir_s = redirect;
        rpc_s = redirect_pc;
        repeat (t_hold[r]) begin
          @(negedge clk);
          if (ack !== 1'b1 || rdata !== rdata_s || redirect !== redir_s ||
              redirect_pc !== rpc_s) begin
            $display("Row %0d: ack or results changed while req was held high", r);
            errors++;
          end
        end
      end
      @(posedge clk);
      req <= 1'b0;
      @(negedge clk); // Req is not yet seen low here.
      lat = 0;
      while (ack !== 1'b0 && lat < ACK_LIMIT) begin
        @(negedge clk);
        lat = lat + 1;
      end
      if (ack !== 1'b0) begin
        $display("Row %0d: ack stayed high %0d cycles after req dropped", r, ACK_LIMIT);
        errors++;
      end else if (lat != 1) begin
        $display("Row %0d: ack fell %0d cycles after req dropped instead of 1", r, lat);
        errors++;
      end
      if (errors == start_errors) n_pass++;
      else n_fail++;
      $display("Row %0d op %0d addr %h: %s", r, t_op[r], t_addr[r],
               (errors == start_errors) ? "ok" : "mismatch");
    end
  endtask

  initial begin
    rst  = 1'b1;
    req  = 1'b0;
    op   = CSR_RW;
    addr = '0;
    src  = '0;
    pc   = '0;
    build_table();
    table_built = 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (ack !== 1'b0) begin
      $display("ack is high after reset although no request was made");
      errors++;
    end
    for (int i = 0; i < n_rows; i++) run_row(i);
    $display("Rows passed: %0d, rows failed: %0d", n_pass, n_fail);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog, scaled to the table length.
  initial begin
    wait (table_built);
    #((8 + n_rows * 10) * 100);
    $display("Watchdog expired before all rows finished");
    $display("Test failed");
    $finish;
  end

endmodule

// File: verilog.f
csr_pkg.sv
csr_regfile.sv
csr_alu.sv
trap_ctrl.sv
csr_req_ctrl.sv
csr_unit.sv
tb_csr_unit.sv

// File: Bender.yml
package:
  name: csr_unit

sources:
  - csr_pkg.sv
  - csr_regfile.sv
  - csr_alu.sv
  - trap_ctrl.sv
  - csr_req_ctrl.sv
  - csr_unit.sv
  - target: test
    files:
      - tb_csr_unit.sv
